//--- sim.f
+incdir+include
hdl/soc_pkg.sv
hdl/mem_block.sv
hdl/timer.sv
hdl/gpio.sv
hdl/sys_bus.sv
hdl/soc_mem_top.sv
testbench/tb_soc_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_soc_mem_top \
    -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- testbench/tb_soc_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module tb_soc_mem_top
    import soc_pkg::*;
();

    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 10;
    localparam int TEST_CYCLES = 2000;
    // first cycles run with every request low
    localparam int IDLE_CYCLES = 20;
    localparam int CYCLE_LIMIT = RST_CYCLES + TEST_CYCLES + 200;

    logic clk = 1'b0;
    logic arst_n;

    addr_t ex_addr, ifu_addr, jtag_addr;
    word_t ex_wdata, ifu_wdata, jtag_wdata;
    word_t ex_rdata, ifu_rdata, jtag_rdata;
    logic  ex_req, ifu_req, jtag_req;
    logic  ex_we, ifu_we, jtag_we;
    logic  hold;
    logic  timer_int;
    logic [`GPIO_W-1:0] gpio_in;
    logic [`GPIO_W-1:0] gpio_out;

    // reference model state
    word_t rom_m [0:`ROM_DEPTH-1];
    logic  rom_ok [0:`ROM_DEPTH-1];
    word_t ram_m [0:`RAM_DEPTH-1];
    logic  ram_ok [0:`RAM_DEPTH-1];
    logic  t_en, t_ie, t_pend;
    word_t t_count, t_value;
    logic [`GPIO_W-1:0] g_out, g_sync, g_in;

    logic [31:0] rng_state;
    int errors = 0;
    int cycles = 0;

    always #HALF_PERIOD clk = ~clk;

    soc_mem_top dut_i (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .ex_addr_i    (ex_addr),
        .ex_wdata_i   (ex_wdata),
        .ex_rdata_o   (ex_rdata),
        .ex_req_i     (ex_req),
        .ex_we_i      (ex_we),
        .ifu_addr_i   (ifu_addr),
        .ifu_wdata_i  (ifu_wdata),
        .ifu_rdata_o  (ifu_rdata),
        .ifu_req_i    (ifu_req),
        .ifu_we_i     (ifu_we),
        .jtag_addr_i  (jtag_addr),
        .jtag_wdata_i (jtag_wdata),
        .jtag_rdata_o (jtag_rdata),
        .jtag_req_i   (jtag_req),
        .jtag_we_i    (jtag_we),
        .hold_o       (hold),
        .timer_int_o  (timer_int),
        .gpio_i       (gpio_in),
        .gpio_o       (gpio_out)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // byte offset inside the slave, select nibble dropped
    function automatic addr_t offset_of(input addr_t a);
        return {4'h0, a[27:0]};
    endfunction

    // spread over rom, ram, timer, gpio and unmapped nibbles
    function automatic addr_t gen_addr(input logic [31:0] r);
        addr_t a;
        logic [3:0] nib;
        case (r[2:0])
            3'd0, 3'd1: a = {`SLAVE_ROM, 19'h0, r[12:6], 2'b00};
            3'd2, 3'd3: a = {`SLAVE_RAM, 19'h0, r[12:6], 2'b00};
            3'd4: begin
                if (r[7:6] == 2'd0)
                    a = {`SLAVE_TIMER, 28'h0} | `TIMER_CTRL_OFS;
                else if (r[7:6] == 2'd1)
                    a = {`SLAVE_TIMER, 28'h0} | `TIMER_COUNT_OFS;
                else
                    a = {`SLAVE_TIMER, 28'h0} | `TIMER_VALUE_OFS;
            end
            3'd5: a = {`SLAVE_GPIO, 28'h0} | (r[6] ? `GPIO_IN_OFS : `GPIO_OUT_OFS);
            default: begin
                nib = r[9:6];
                // fold 0..3 up into the unmapped range
                if (nib < 4'd4)
                    nib = nib + 4'd4;
                a = {nib, r[31:4]};
            end
        endcase
        return a;
    endfunction

    // small count and compare values so the timer wraps now and then
    function automatic word_t gen_wdata(input addr_t a, input logic [31:0] r);
        if (a[31:28] == `SLAVE_TIMER && offset_of(a) != `TIMER_CTRL_OFS)
            return {27'h0, r[4:0]};
        return r;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_gpio(input string name, input logic [`GPIO_W-1:0] got,
                              input logic [`GPIO_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // value a slave would return, known is low for unwritten memory
    task automatic model_read(input addr_t a, output word_t val, output logic known,
                              output logic hit);
        addr_t ofs;
        logic [7:0] idx;
        ofs   = offset_of(a);
        idx   = a[9:2];
        val   = '0;
        known = 1'b1;
        hit   = 1'b1;
        case (a[31:28])
            `SLAVE_ROM: begin
                val   = rom_m[idx];
                known = rom_ok[idx];
            end
            `SLAVE_RAM: begin
                val   = ram_m[idx];
                known = ram_ok[idx];
            end
            `SLAVE_TIMER: begin
                if (ofs == `TIMER_CTRL_OFS)
                    val = {29'h0, t_pend, t_ie, t_en};
                else if (ofs == `TIMER_COUNT_OFS)
                    val = t_count;
                else if (ofs == `TIMER_VALUE_OFS)
                    val = t_value;
            end
            `SLAVE_GPIO: begin
                if (ofs == `GPIO_OUT_OFS)
                    val = {{(`MEM_DATA_W-`GPIO_W){1'b0}}, g_out};
                else if (ofs == `GPIO_IN_OFS)
                    val = {{(`MEM_DATA_W-`GPIO_W){1'b0}}, g_in};
            end
            default: hit = 1'b0;
        endcase
    endtask

    // all outputs are stable here, just before the rising edge
    task automatic check_outputs();
        word_t val;
        logic known;
        logic hit;
        check_bit("hold_o", hold, ex_req | jtag_req);
        check_bit("timer_int_o", timer_int, t_pend & t_ie);
        check_gpio("gpio_o", gpio_out, g_out);
        if (ex_req) begin
            model_read(ex_addr, val, known, hit);
            if (known)
                check_word("ex_rdata_o", ex_rdata, val);
            check_word("jtag_rdata_o", jtag_rdata, '0);
            check_word("ifu_rdata_o", ifu_rdata, `INST_NOP);
        end else if (jtag_req) begin
            model_read(jtag_addr, val, known, hit);
            if (known)
                check_word("jtag_rdata_o", jtag_rdata, val);
            check_word("ex_rdata_o", ex_rdata, '0);
            check_word("ifu_rdata_o", ifu_rdata, `INST_NOP);
        end else begin
            // fetch owns the bus, request or not
            model_read(ifu_addr, val, known, hit);
            if (!hit)
                val = `INST_NOP;
            if (known)
                check_word("ifu_rdata_o", ifu_rdata, val);
            check_word("ex_rdata_o", ex_rdata, '0);
            check_word("jtag_rdata_o", jtag_rdata, '0);
        end
    endtask

    // model state after the coming rising edge
    task automatic advance_model();
        addr_t a;
        addr_t ofs;
        word_t d;
        logic we;
        logic hit_t;
        logic ctrl_wr, count_wr, value_wr;
        logic [7:0] idx;
        if (ex_req) begin
            a  = ex_addr;
            d  = ex_wdata;
            we = ex_we;
        end else if (jtag_req) begin
            a  = jtag_addr;
            d  = jtag_wdata;
            we = jtag_we;
        end else begin
            // fetch writes only when it asks
            a  = ifu_addr;
            d  = ifu_wdata;
            we = ifu_we & ifu_req;
        end
        ofs      = offset_of(a);
        idx      = a[9:2];
        ctrl_wr  = we && (a[31:28] == `SLAVE_TIMER) && (ofs == `TIMER_CTRL_OFS);
        count_wr = we && (a[31:28] == `SLAVE_TIMER) && (ofs == `TIMER_COUNT_OFS);
        value_wr = we && (a[31:28] == `SLAVE_TIMER) && (ofs == `TIMER_VALUE_OFS);
        if (we && a[31:28] == `SLAVE_ROM) begin
            rom_m[idx]  = d;
            rom_ok[idx] = 1'b1;
        end
        if (we && a[31:28] == `SLAVE_RAM) begin
            ram_m[idx]  = d;
            ram_ok[idx] = 1'b1;
        end
        if (we && a[31:28] == `SLAVE_GPIO && ofs == `GPIO_OUT_OFS)
            g_out = d[`GPIO_W-1:0];
        // two-deep input history
        g_in   = g_sync;
        g_sync = gpio_in;
        // match only while enabled, on the old count
        hit_t = t_en && (t_count == t_value);
        if (count_wr)
            t_count = d;
        else if (hit_t)
            t_count = '0;
        else if (t_en)
            t_count = t_count + 32'd1;
        // a match keeps pending even against a clear
        if (hit_t)
            t_pend = 1'b1;
        else if (ctrl_wr && d[2])
            t_pend = 1'b0;
        if (ctrl_wr) begin
            t_en = d[0];
            t_ie = d[1];
        end
        if (value_wr)
            t_value = d;
    endtask

    task automatic drive_inputs(input logic allow_req);
        logic [31:0] r;
        r = draw_rand();
        // ex and jtag ask a quarter of the time so fetch gets turns
        ex_req   = allow_req && (r[1:0] == 2'b00);
        jtag_req = allow_req && (r[3:2] == 2'b00);
        ifu_req  = allow_req & r[4];
        ex_we    = r[5];
        jtag_we  = r[6];
        ifu_we   = r[7];
        if (r[8])
            gpio_in = r[31:16];
        ex_addr    = gen_addr(draw_rand());
        ex_wdata   = gen_wdata(ex_addr, draw_rand());
        jtag_addr  = gen_addr(draw_rand());
        jtag_wdata = gen_wdata(jtag_addr, draw_rand());
        ifu_addr   = gen_addr(draw_rand());
        ifu_wdata  = gen_wdata(ifu_addr, draw_rand());
    endtask

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: test did not finish");
            errors++;
            $display("errors: %0d", errors);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        rng_state  = 32'h217c;
        arst_n     = 1'b0;
        ex_addr    = '0;
        ex_wdata   = '0;
        ex_req     = 1'b0;
        ex_we      = 1'b0;
        ifu_addr   = '0;
        ifu_wdata  = '0;
        ifu_req    = 1'b0;
        ifu_we     = 1'b0;
        jtag_addr  = '0;
        jtag_wdata = '0;
        jtag_req   = 1'b0;
        jtag_we    = 1'b0;
        gpio_in    = '0;
        // model matches the reset values
        t_en    = 1'b0;
        t_ie    = 1'b0;
        t_pend  = 1'b0;
        t_count = '0;
        t_value = '0;
        g_out   = '0;
        g_sync  = '0;
        g_in    = '0;
        for (int k = 0; k < `ROM_DEPTH; k++) begin
            rom_m[k]  = '0;
            rom_ok[k] = 1'b0;
        end
        for (int k = 0; k < `RAM_DEPTH; k++) begin
            ram_m[k]  = '0;
            ram_ok[k] = 1'b0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < TEST_CYCLES; i++) begin
            drive_inputs(i >= IDLE_CYCLES);
            #(HALF_PERIOD - 10);
            check_outputs();
            advance_model();
            @(negedge clk);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/soc_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module soc_mem_top
    import soc_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n_i,

    input  wire addr_t         ex_addr_i,
    input  wire word_t         ex_wdata_i,
    output word_t              ex_rdata_o,
    input  wire                ex_req_i,
    input  wire                ex_we_i,

    input  wire addr_t         ifu_addr_i,
    input  wire word_t         ifu_wdata_i,
    output word_t              ifu_rdata_o,
    input  wire                ifu_req_i,
    input  wire                ifu_we_i,

    input  wire addr_t         jtag_addr_i,
    input  wire word_t         jtag_wdata_i,
    output word_t              jtag_rdata_o,
    input  wire                jtag_req_i,
    input  wire                jtag_we_i,

    output logic               hold_o,
    output logic               timer_int_o,
    input  wire [`GPIO_W-1:0]  gpio_i,
    output logic [`GPIO_W-1:0] gpio_o
);

    // s0 rom, s1 ram, s2 timer, s3 gpio
    addr_t s0_addr, s1_addr, s2_addr, s3_addr;
    word_t s0_wdata, s1_wdata, s2_wdata, s3_wdata;
    word_t s0_rdata, s1_rdata, s2_rdata, s3_rdata;
    logic  s0_we, s1_we, s2_we, s3_we;

    sys_bus u_bus (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .ex_addr_i    (ex_addr_i),
        .ex_wdata_i   (ex_wdata_i),
        .ex_rdata_o   (ex_rdata_o),
        .ex_req_i     (ex_req_i),
        .ex_we_i      (ex_we_i),
        .ifu_addr_i   (ifu_addr_i),
        .ifu_wdata_i  (ifu_wdata_i),
        .ifu_rdata_o  (ifu_rdata_o),
        .ifu_req_i    (ifu_req_i),
        .ifu_we_i     (ifu_we_i),
        .jtag_addr_i  (jtag_addr_i),
        .jtag_wdata_i (jtag_wdata_i),
        .jtag_rdata_o (jtag_rdata_o),
        .jtag_req_i   (jtag_req_i),
        .jtag_we_i    (jtag_we_i),
        .s0_addr_o    (s0_addr),
        .s0_wdata_o   (s0_wdata),
        .s0_rdata_i   (s0_rdata),
        .s0_we_o      (s0_we),
        .s1_addr_o    (s1_addr),
        .s1_wdata_o   (s1_wdata),
        .s1_rdata_i   (s1_rdata),
        .s1_we_o      (s1_we),
        .s2_addr_o    (s2_addr),
        .s2_wdata_o   (s2_wdata),
        .s2_rdata_i   (s2_rdata),
        .s2_we_o      (s2_we),
        .s3_addr_o    (s3_addr),
        .s3_wdata_o   (s3_wdata),
        .s3_rdata_i   (s3_rdata),
        .s3_we_o      (s3_we),
        .hold_o       (hold_o)
    );

    // instruction memory, jtag loads it through the bus
    mem_block #(.DEPTH(`ROM_DEPTH)) u_rom (
        .clk     (clk),
        .addr_i  (s0_addr),
        .wdata_i (s0_wdata),
        .we_i    (s0_we),
        .rdata_o (s0_rdata)
    );

    mem_block #(.DEPTH(`RAM_DEPTH)) u_ram (
        .clk     (clk),
        .addr_i  (s1_addr),
        .wdata_i (s1_wdata),
        .we_i    (s1_we),
        .rdata_o (s1_rdata)
    );

    timer u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .addr_i   (s2_addr),
        .wdata_i  (s2_wdata),
        .we_i     (s2_we),
        .rdata_o  (s2_rdata),
        .int_o    (timer_int_o)
    );

    gpio u_gpio (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .addr_i   (s3_addr),
        .wdata_i  (s3_wdata),
        .we_i     (s3_we),
        .rdata_o  (s3_rdata),
        .gpio_i   (gpio_i),
        .gpio_o   (gpio_o)
    );

endmodule

`default_nettype wire

//--- hdl/sys_bus.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module sys_bus
    import soc_pkg::*;
(
    input  wire        clk,
    input  wire        arst_n_i,

    // execute stage
    input  wire addr_t ex_addr_i,
    input  wire word_t ex_wdata_i,
    output word_t      ex_rdata_o,
    input  wire        ex_req_i,
    input  wire        ex_we_i,

    // instruction fetch
    input  wire addr_t ifu_addr_i,
    input  wire word_t ifu_wdata_i,
    output word_t      ifu_rdata_o,
    input  wire        ifu_req_i,
    input  wire        ifu_we_i,

    // debug port
    input  wire addr_t jtag_addr_i,
    input  wire word_t jtag_wdata_i,
    output word_t      jtag_rdata_o,
    input  wire        jtag_req_i,
    input  wire        jtag_we_i,

    // rom
    output addr_t      s0_addr_o,
    output word_t      s0_wdata_o,
    input  wire word_t s0_rdata_i,
    output logic       s0_we_o,

    // ram
    output addr_t      s1_addr_o,
    output word_t      s1_wdata_o,
    input  wire word_t s1_rdata_i,
    output logic       s1_we_o,

    // timer
    output addr_t      s2_addr_o,
    output word_t      s2_wdata_o,
    input  wire word_t s2_rdata_i,
    output logic       s2_we_o,

    // gpio
    output addr_t      s3_addr_o,
    output word_t      s3_wdata_o,
    input  wire word_t s3_rdata_i,
    output logic       s3_we_o,

    output logic       hold_o
);

    localparam int SEL_W = `SLAVE_SEL_HI - `SLAVE_SEL_LO + 1;

    grant_t           grant;
    addr_t            m_addr;
    word_t            m_wdata;
    logic             m_we;
    logic [SEL_W-1:0] sel;
    addr_t            s_addr;
    word_t            s_rdata;
    logic             s_hit;

    // fixed priority ex > jtag > ifu
    // ifu owns the bus by default even without a request
    always_comb begin
        if (ex_req_i) begin
            grant = GRANT_EX;
        end else if (jtag_req_i) begin
            grant = GRANT_JTAG;
        end else begin
            grant = GRANT_IFU;
        end
    end

    // stall the pipeline whenever fetch loses the bus
    assign hold_o = (grant != GRANT_IFU);

    // pick the owning master's access
    always_comb begin
        case (grant)
            GRANT_EX: begin
                m_addr  = ex_addr_i;
                m_wdata = ex_wdata_i;
                m_we    = ex_we_i;
            end
            GRANT_JTAG: begin
                m_addr  = jtag_addr_i;
                m_wdata = jtag_wdata_i;
                m_we    = jtag_we_i;
            end
            default: begin
                m_addr  = ifu_addr_i;
                m_wdata = ifu_wdata_i;
                m_we    = ifu_we_i & ifu_req_i;
            end
        endcase
    end

    assign sel = m_addr[`SLAVE_SEL_HI:`SLAVE_SEL_LO];
    // slaves see the offset with the select nibble cleared
    assign s_addr = {{SEL_W{1'b0}}, m_addr[`SLAVE_SEL_LO-1:0]};

    // slave decode with unselected slaves idle at zero
    always_comb begin
        s0_addr_o  = '0;
        s0_wdata_o = '0;
        s0_we_o    = 1'b0;
        s1_addr_o  = '0;
        s1_wdata_o = '0;
        s1_we_o    = 1'b0;
        s2_addr_o  = '0;
        s2_wdata_o = '0;
        s2_we_o    = 1'b0;
        s3_addr_o  = '0;
        s3_wdata_o = '0;
        s3_we_o    = 1'b0;
        s_rdata    = '0;
        s_hit      = 1'b1;
        case (sel)
            `SLAVE_ROM: begin
                s0_addr_o  = s_addr;
                s0_wdata_o = m_wdata;
                s0_we_o    = m_we;
                s_rdata    = s0_rdata_i;
            end
            `SLAVE_RAM: begin
                s1_addr_o  = s_addr;
                s1_wdata_o = m_wdata;
                s1_we_o    = m_we;
                s_rdata    = s1_rdata_i;
            end
            `SLAVE_TIMER: begin
                s2_addr_o  = s_addr;
                s2_wdata_o = m_wdata;
                s2_we_o    = m_we;
                s_rdata    = s2_rdata_i;
            end
            `SLAVE_GPIO: begin
                s3_addr_o  = s_addr;
                s3_wdata_o = m_wdata;
                s3_we_o    = m_we;
                s_rdata    = s3_rdata_i;
            end
            // unmapped nibble reaches nothing
            default: s_hit = 1'b0;
        endcase
    end

    // read data back to the owner only
    always_comb begin
        ex_rdata_o   = '0;
        jtag_rdata_o = '0;
        ifu_rdata_o  = `INST_NOP;
        case (grant)
            GRANT_EX:   ex_rdata_o   = s_rdata;
            GRANT_JTAG: jtag_rdata_o = s_rdata;
            default: begin
                if (s_hit) begin
                    ifu_rdata_o = s_rdata;
                end
            end
        endcase
    end

    // a write never fans out to two slaves
    assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({s0_we_o, s1_we_o, s2_we_o, s3_we_o}))
        else $error("sys_bus: several slave write enables at once");

    // arbitration raises hold exactly on an ex or jtag request
    assert property (@(posedge clk) disable iff (!arst_n_i)
        hold_o == (ex_req_i || jtag_req_i))
        else $error("sys_bus: hold does not match arbitration");

endmodule

`default_nettype wire

//--- hdl/gpio.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module gpio
    import soc_pkg::*;
(
    input  wire                clk,
    input  wire                arst_n_i,
    input  wire addr_t         addr_i,
    input  wire word_t         wdata_i,
    input  wire                we_i,
    output word_t              rdata_o,
    input  wire [`GPIO_W-1:0]  gpio_i,
    output logic [`GPIO_W-1:0] gpio_o
);

    logic [`GPIO_W-1:0] out_q;
    // first stage may go metastable
    logic [`GPIO_W-1:0] sync_q;
    // input register, two edges behind the pins
    logic [`GPIO_W-1:0] in_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
        end else if (we_i && (addr_i == `GPIO_OUT_OFS)) begin
            out_q <= wdata_i[`GPIO_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
            in_q   <= '0;
        end else begin
            sync_q <= gpio_i;
            in_q   <= sync_q;
        end
    end

    assign gpio_o = out_q;

    // input offset is read only
    always_comb begin
        case (addr_i)
            `GPIO_OUT_OFS: rdata_o = {{(`MEM_DATA_W-`GPIO_W){1'b0}}, out_q};
            `GPIO_IN_OFS:  rdata_o = {{(`MEM_DATA_W-`GPIO_W){1'b0}}, in_q};
            default:       rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/timer.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module timer
    import soc_pkg::*;
(
    input  wire        clk,
    input  wire        arst_n_i,
    input  wire addr_t addr_i,
    input  wire word_t wdata_i,
    input  wire        we_i,
    output word_t      rdata_o,
    output logic       int_o
);

    // ctrl bits: 0 enable, 1 irq enable, 2 pending
    logic  ctrl_en;
    logic  ctrl_ie;
    logic  pending;
    word_t count;
    word_t cmp_value;

    logic  ctrl_wr;
    logic  count_wr;
    logic  value_wr;
    logic  hit;

    assign ctrl_wr  = we_i && (addr_i == `TIMER_CTRL_OFS);
    assign count_wr = we_i && (addr_i == `TIMER_COUNT_OFS);
    assign value_wr = we_i && (addr_i == `TIMER_VALUE_OFS);

    // compare match only counts while running
    assign hit = ctrl_en && (count == cmp_value);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_en   <= 1'b0;
            ctrl_ie   <= 1'b0;
            pending   <= 1'b0;
            count     <= '0;
            cmp_value <= '0;
        end else begin
            if (ctrl_wr) begin
                ctrl_en <= wdata_i[0];
                ctrl_ie <= wdata_i[1];
            end
            if (value_wr) begin
                cmp_value <= wdata_i;
            end
            // software load beats counting
            if (count_wr) begin
                count <= wdata_i;
            end else if (hit) begin
                count <= '0;
            end else if (ctrl_en) begin
                count <= count + 32'd1;
            end
            // new match wins over write-one-to-clear, no event lost
            if (hit) begin
                pending <= 1'b1;
            end else if (ctrl_wr && wdata_i[2]) begin
                pending <= 1'b0;
            end
        end
    end

    assign int_o = pending & ctrl_ie;

    always_comb begin
        case (addr_i)
            `TIMER_CTRL_OFS:  rdata_o = {{(`MEM_DATA_W-3){1'b0}}, pending, ctrl_ie, ctrl_en};
            `TIMER_COUNT_OFS: rdata_o = count;
            `TIMER_VALUE_OFS: rdata_o = cmp_value;
            default:          rdata_o = '0;
        endcase
    end

    // irq edge needs ie set and a match or ie write the cycle before
    assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(int_o) |-> ctrl_ie && $past(hit || (ctrl_wr && wdata_i[1])))
        else $error("timer: interrupt raised without cause");

endmodule

`default_nettype wire

//--- hdl/mem_block.sv
`timescale 1ns/1ns
`default_nettype none

`include "soc_macros.svh"

module mem_block
    import soc_pkg::*;
#(
    parameter int DEPTH = `RAM_DEPTH
) (
    input  wire        clk,
    input  wire addr_t addr_i,
    input  wire word_t wdata_i,
    input  wire        we_i,
    output word_t      rdata_o
);

    localparam int IDX_W = $clog2(DEPTH);

    // word storage, contents undefined until written
    word_t mem [0:DEPTH-1];

    logic [IDX_W-1:0] idx;

    // byte address to word index, wraps at DEPTH
    assign idx = addr_i[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[idx] <= wdata_i;
        end
    end

    // combinational read, same cycle as the address
    assign rdata_o = mem[idx];

    // writes stay inside the array without relying on the wrap
    assert property (@(posedge clk)
        we_i |-> (addr_i[`MEM_ADDR_W-1:IDX_W+2] == '0))
        else $error("mem_block: write beyond DEPTH words");

endmodule

`default_nettype wire

//--- hdl/soc_pkg.sv
`default_nettype none

`include "soc_macros.svh"

package soc_pkg;

    // one bus data word
    typedef logic [`MEM_DATA_W-1:0] word_t;

    // byte address, select nibble on top
    typedef logic [`MEM_ADDR_W-1:0] addr_t;

    // owner of the bus this cycle
    typedef enum logic [1:0] {
        GRANT_EX   = 2'd0,
        GRANT_IFU  = 2'd1,
        GRANT_JTAG = 2'd2
    } grant_t;

endpackage

`default_nettype wire

//--- include/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// top address nibble picks the slave
`define SLAVE_SEL_HI 31
`define SLAVE_SEL_LO 28
`define SLAVE_ROM   4'h0
`define SLAVE_RAM   4'h1
`define SLAVE_TIMER 4'h2
`define SLAVE_GPIO  4'h3

// words per memory
`define ROM_DEPTH 256
`define RAM_DEPTH 256

`define GPIO_W 16

// addi x0, x0, 0 for fetch with nothing behind it
`define INST_NOP 32'h0000_0013

// register byte offsets inside a slave
`define TIMER_CTRL_OFS  32'h0000_0000
`define TIMER_COUNT_OFS 32'h0000_0004
`define TIMER_VALUE_OFS 32'h0000_0008
`define GPIO_OUT_OFS    32'h0000_0000
`define GPIO_IN_OFS     32'h0000_0004

`endif
